// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dispatchTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

SRCS := $(wildcard logic/*.sv verif/*.sv include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== include/dispatch_params.svh ====
`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

//////////////////////////////
// Group shape
//////////////////////////////

`define DISPATCH_WIDTH      4   // Instructions per group

//////////////////////////////
// Branch checkpoints
//////////////////////////////

`define CHECKPOINTS         8   // One mask bit per checkpoint
`define CHECKPOINTS_LOG     3

//////////////////////////////
// Instruction fields
//////////////////////////////

`define SIZE_PHYSICAL_LOG   7   // Physical register tag
`define SIZE_RMT_LOG        5   // Logical register id
`define SIZE_PC             32
`define SIZE_OPCODE         8
`define SIZE_IMMEDIATE      16

//////////////////////////////
// Back-end capacities
//////////////////////////////

// Count widths are one bit wider than the _LOG values
`define SIZE_LSQ            16  // Load queue and store queue each
`define SIZE_LSQ_LOG        4
`define SIZE_ISSUEQ         32
`define SIZE_ISSUEQ_LOG     5
`define SIZE_ACTIVELIST     64
`define SIZE_ACTIVELIST_LOG 6

`endif

// ==== logic/backendOccupancyPkg.sv ====
`include "dispatch_params.svh"

package backendOccupancyPkg;

  // Counts reach capacity itself, hence the extra bit
  typedef logic [`SIZE_LSQ_LOG:0]        lsqCntT;
  typedef logic [`SIZE_ISSUEQ_LOG:0]     issueqCntT;
  typedef logic [`SIZE_ACTIVELIST_LOG:0] alCntT;

  typedef struct packed {
    lsqCntT    loadQueueCnt;   // Entries in use
    lsqCntT    storeQueueCnt;
    issueqCntT issueQueueCnt;
    alCntT     activeListCnt;
  } occupancyT;

  typedef struct packed {
    logic loadFull;
    logic storeFull;
    logic issueqFull;
    logic alFull;
  } stallReasonT;

endpackage

// ==== logic/backendPacketSplit.sv ====
`timescale 1ns/10ps
`include "dispatch_params.svh"

module backendPacketSplit
(
  input  instPacketPkg::renamedInstT  [`DISPATCH_WIDTH-1:0] renamed_i,
  input  instPacketPkg::branchMaskT   [`DISPATCH_WIDTH-1:0] updatedMask_i,
  output instPacketPkg::issueqPacketT [`DISPATCH_WIDTH-1:0] issueqPacket_o,
  output instPacketPkg::alPacketT     [`DISPATCH_WIDTH-1:0] alPacket_o,
  output instPacketPkg::lsqPacketT    [`DISPATCH_WIDTH-1:0] lsqPacket_o
);

  always_comb
  begin
    for (int lane = 0; lane < `DISPATCH_WIDTH; lane++)
    begin
      //////////////////////////////
      // Issue queue
      //////////////////////////////
      issueqPacket_o[lane].isBranch     = renamed_i[lane].isBranch;
      issueqPacket_o[lane].isStore      = renamed_i[lane].isStore;
      issueqPacket_o[lane].isLoad       = renamed_i[lane].isLoad;
      issueqPacket_o[lane].branchMask   = updatedMask_i[lane];   // Not the incoming mask
      issueqPacket_o[lane].checkpointId = renamed_i[lane].checkpointId;
      issueqPacket_o[lane].physSrc1     = renamed_i[lane].physSrc1;
      issueqPacket_o[lane].physSrc2     = renamed_i[lane].physSrc2;
      issueqPacket_o[lane].physDest     = renamed_i[lane].physDest;
      issueqPacket_o[lane].physOldDest  = renamed_i[lane].physOldDest;
      issueqPacket_o[lane].opcode       = renamed_i[lane].opcode;
      issueqPacket_o[lane].immediate    = renamed_i[lane].immediate;
      issueqPacket_o[lane].pc           = renamed_i[lane].pc;

      //////////////////////////////
      // Active list
      //////////////////////////////
      alPacket_o[lane].isLoad      = renamed_i[lane].isLoad;
      alPacket_o[lane].isStore     = renamed_i[lane].isStore;
      alPacket_o[lane].pc          = renamed_i[lane].pc;
      alPacket_o[lane].logDest     = renamed_i[lane].logDest;       // Arch state at commit
      alPacket_o[lane].physDest    = renamed_i[lane].physDest;
      alPacket_o[lane].physOldDest = renamed_i[lane].physOldDest;

      // Load/store queue only needs type and branch dependence
      lsqPacket_o[lane].branchMask = updatedMask_i[lane];
      lsqPacket_o[lane].isStore    = renamed_i[lane].isStore;
      lsqPacket_o[lane].isLoad     = renamed_i[lane].isLoad;
    end
  end

endmodule

// ==== logic/backendSpaceCheck.sv ====
`timescale 1ns/10ps
`include "dispatch_params.svh"

module backendSpaceCheck
(
  input  instPacketPkg::renamedInstT [`DISPATCH_WIDTH-1:0] renamed_i,
  input  backendOccupancyPkg::occupancyT                   occupancy_i,
  output backendOccupancyPkg::stallReasonT                 stallReason_o
);

  localparam int CntW = $clog2(`DISPATCH_WIDTH + 1);   // Holds 0..DISPATCH_WIDTH

  logic [CntW-1:0]                  loadCnt;
  logic [CntW-1:0]                  storeCnt;
  logic [`SIZE_LSQ_LOG+1:0]         loadSum;     // Carry bit for the compare
  logic [`SIZE_LSQ_LOG+1:0]         storeSum;
  logic [`SIZE_ISSUEQ_LOG+1:0]      issueqSum;
  logic [`SIZE_ACTIVELIST_LOG+1:0]  alSum;

  //////////////////////////////
  // Load and store count
  //////////////////////////////

  always_comb
  begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int lane = 0; lane < `DISPATCH_WIDTH; lane++)
    begin
      loadCnt  = loadCnt  + CntW'(renamed_i[lane].isLoad);    // Same field on every lane
      storeCnt = storeCnt + CntW'(renamed_i[lane].isStore);
    end
  end

  //////////////////////////////
  // Room in each structure
  //////////////////////////////

  // Issue queue and active list take a full group regardless of content
  assign loadSum   = occupancy_i.loadQueueCnt  + loadCnt;
  assign storeSum  = occupancy_i.storeQueueCnt + storeCnt;
  assign issueqSum = occupancy_i.issueQueueCnt + `DISPATCH_WIDTH;
  assign alSum     = occupancy_i.activeListCnt + `DISPATCH_WIDTH;

  assign stallReason_o.loadFull   = (loadSum   > `SIZE_LSQ);
  assign stallReason_o.storeFull  = (storeSum  > `SIZE_LSQ);
  assign stallReason_o.issueqFull = (issueqSum > `SIZE_ISSUEQ);
  assign stallReason_o.alFull     = (alSum     > `SIZE_ACTIVELIST);

endmodule

// ==== logic/branchMaskUpdate.sv ====
`timescale 1ns/10ps
`include "dispatch_params.svh"

module branchMaskUpdate
(
  input  instPacketPkg::renamedInstT  [`DISPATCH_WIDTH-1:0] renamed_i,
  input  logic                                              ctrlVerified_i,
  input  instPacketPkg::checkpointIdT                       ctrlVerifiedId_i,
  output instPacketPkg::branchMaskT   [`DISPATCH_WIDTH-1:0] updatedMask_o
);

  instPacketPkg::branchMaskT clearMask;   // Bit of the verified checkpoint

  // A correctly resolved branch frees its checkpoint, so younger
  // instructions no longer depend on it
  always_comb
  begin
    clearMask = '0;
    if (ctrlVerified_i)
    begin
      clearMask[ctrlVerifiedId_i] = 1'b1;
    end
  end

  always_comb
  begin
    for (int lane = 0; lane < `DISPATCH_WIDTH; lane++)
    begin
      updatedMask_o[lane] = renamed_i[lane].branchMask & ~clearMask;   // Same for every lane
    end
  end

endmodule

// ==== logic/dispatch.sv ====
`timescale 1ns/10ps
`include "dispatch_params.svh"

module dispatch
(
  input  logic                                              renameReady_i,     // Rename has a group
  input  logic                                              flagRecoverEx_i,   // Recovery in execute
  input  logic                                              ctrlVerified_i,
  input  instPacketPkg::checkpointIdT                       ctrlVerifiedId_i,
  input  instPacketPkg::renamedInstT  [`DISPATCH_WIDTH-1:0] renamedPacket_i,
  input  backendOccupancyPkg::occupancyT                    occupancy_i,

  output instPacketPkg::issueqPacketT [`DISPATCH_WIDTH-1:0] issueqPacket_o,
  output instPacketPkg::alPacketT     [`DISPATCH_WIDTH-1:0] alPacket_o,
  output instPacketPkg::lsqPacketT    [`DISPATCH_WIDTH-1:0] lsqPacket_o,
  // Written back into the rename/dispatch pipeline register during a stall
  output instPacketPkg::branchMaskT   [`DISPATCH_WIDTH-1:0] updatedBranchMask_o,
  output logic                                              backEndReady_o,
  output logic                                              stallFrontEnd_o
);

  instPacketPkg::branchMaskT [`DISPATCH_WIDTH-1:0] updatedMask;
  backendOccupancyPkg::stallReasonT                stallReason;

  //////////////////////////////
  // Submodules
  //////////////////////////////

  branchMaskUpdate maskUpdate
  (
    .renamed_i        (renamedPacket_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .updatedMask_o    (updatedMask)
  );

  backendSpaceCheck spaceCheck
  (
    .renamed_i     (renamedPacket_i),
    .occupancy_i   (occupancy_i),
    .stallReason_o (stallReason)
  );

  backendPacketSplit packetSplit
  (
    .renamed_i      (renamedPacket_i),
    .updatedMask_i  (updatedMask),
    .issueqPacket_o (issueqPacket_o),
    .alPacket_o     (alPacket_o),
    .lsqPacket_o    (lsqPacket_o)
  );

  //////////////////////////////
  // Stall and ready
  //////////////////////////////

  assign updatedBranchMask_o = updatedMask;

  assign stallFrontEnd_o = |stallReason;   // Any full structure holds the group

  // Group leaves rename only with room, a group present and no recovery
  assign backEndReady_o = ~stallFrontEnd_o & renameReady_i & ~flagRecoverEx_i;

endmodule

// ==== logic/instPacketPkg.sv ====
`include "dispatch_params.svh"

package instPacketPkg;

  //////////////////////////////
  // Branch checkpoint types
  //////////////////////////////

  typedef logic [`CHECKPOINTS-1:0]     branchMaskT;     // One bit per open checkpoint
  typedef logic [`CHECKPOINTS_LOG-1:0] checkpointIdT;

  //////////////////////////////
  // Renamed instruction
  //////////////////////////////

  typedef struct packed {
    logic [`SIZE_RMT_LOG-1:0]      logDest;      // Needed by active list only
    logic                          isBranch;
    logic                          isStore;
    logic                          isLoad;
    branchMaskT                    branchMask;   // Unresolved branches ahead
    checkpointIdT                  checkpointId;
    logic [`SIZE_PHYSICAL_LOG-1:0] physSrc1;
    logic [`SIZE_PHYSICAL_LOG-1:0] physSrc2;
    logic [`SIZE_PHYSICAL_LOG-1:0] physDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] physOldDest;  // Freed at commit
    logic [`SIZE_OPCODE-1:0]       opcode;
    logic [`SIZE_IMMEDIATE-1:0]    immediate;
    logic [`SIZE_PC-1:0]           pc;
  } renamedInstT;

  //////////////////////////////
  // Back-end packets
  //////////////////////////////

  // Issue queue sees everything but the logical destination
  typedef struct packed {
    logic                          isBranch;
    logic                          isStore;
    logic                          isLoad;
    branchMaskT                    branchMask;   // Already updated
    checkpointIdT                  checkpointId;
    logic [`SIZE_PHYSICAL_LOG-1:0] physSrc1;
    logic [`SIZE_PHYSICAL_LOG-1:0] physSrc2;
    logic [`SIZE_PHYSICAL_LOG-1:0] physDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] physOldDest;
    logic [`SIZE_OPCODE-1:0]       opcode;
    logic [`SIZE_IMMEDIATE-1:0]    immediate;
    logic [`SIZE_PC-1:0]           pc;
  } issueqPacketT;

  typedef struct packed {
    logic                          isLoad;
    logic                          isStore;
    logic [`SIZE_PC-1:0]           pc;
    logic [`SIZE_RMT_LOG-1:0]      logDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] physDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] physOldDest;
  } alPacketT;

  typedef struct packed {
    branchMaskT branchMask;
    logic       isStore;
    logic       isLoad;
  } lsqPacketT;

endpackage

// ==== sources.f ====
+incdir+include
logic/instPacketPkg.sv
logic/backendOccupancyPkg.sv
logic/branchMaskUpdate.sv
logic/backendSpaceCheck.sv
logic/backendPacketSplit.sv
logic/dispatch.sv
verif/clockGen.sv
verif/dispatchTb.sv

// ==== verif/clockGen.sv ====
`timescale 1ns/10ps

module clockGen
(
  output logic clk_o,
  output logic arstN_o
);

  localparam int HalfPeriod  = 20;   // 40 ns clock
  localparam int ResetCycles = 8;

  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #HalfPeriod clk_o = ~clk_o;
    end
  end

  initial
  begin
    arstN_o = 1'b0;                  // Held low from time zero
    repeat (ResetCycles) @(posedge clk_o);
    arstN_o <= 1'b1;
  end

endmodule

// ==== verif/dispatchTb.sv ====
`timescale 1ns/10ps
`include "dispatch_params.svh"

module dispatchTb;

  typedef instPacketPkg::renamedInstT [`DISPATCH_WIDTH-1:0] groupT;

  localparam int ResetTimeout = 50;    // Cycles allowed for reset release
  localparam int RandomGroups = 200;

  logic clk;
  logic arstN_i;

  logic                                                renameReady;
  logic                                                flagRecoverEx;
  logic                                                ctrlVerified;
  instPacketPkg::checkpointIdT                         ctrlVerifiedId;
  groupT                                               renamed;
  backendOccupancyPkg::occupancyT                      occupancy;
  instPacketPkg::issueqPacketT [`DISPATCH_WIDTH-1:0]   issueqPacket;
  instPacketPkg::alPacketT     [`DISPATCH_WIDTH-1:0]   alPacket;
  instPacketPkg::lsqPacketT    [`DISPATCH_WIDTH-1:0]   lsqPacket;
  instPacketPkg::branchMaskT   [`DISPATCH_WIDTH-1:0]   updatedBranchMask;
  logic                                                backEndReady;
  logic                                                stallFrontEnd;

  clockGen clocks
  (
    .clk_o   (clk),
    .arstN_o (arstN_i)
  );

  dispatch dut
  (
    .renameReady_i       (renameReady),
    .flagRecoverEx_i     (flagRecoverEx),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .renamedPacket_i     (renamed),
    .occupancy_i         (occupancy),
    .issueqPacket_o      (issueqPacket),
    .alPacket_o          (alPacket),
    .lsqPacket_o         (lsqPacket),
    .updatedBranchMask_o (updatedBranchMask),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd)
  );

  //////////////////////////////
  // Failure reporting
  //////////////////////////////

  task automatic endInFailure();
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic failMismatch(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
    $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    endInFailure();
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic groupT randomGroup();
    groupT        grp;
    logic [127:0] raw;
    for (int l = 0; l < `DISPATCH_WIDTH; l++)
    begin
      raw    = {$urandom(), $urandom(), $urandom(), $urandom()};
      grp[l] = raw[$bits(instPacketPkg::renamedInstT)-1:0];
    end
    return grp;
  endfunction

  // Loads fill the low lanes, stores the high lanes
  function automatic groupT mixGroup(input int loads, input int stores);
    groupT grp;
    grp = randomGroup();
    for (int l = 0; l < `DISPATCH_WIDTH; l++)
    begin
      grp[l].isLoad  = (l < loads);
      grp[l].isStore = (l >= `DISPATCH_WIDTH - stores);
    end
    return grp;
  endfunction

  function automatic backendOccupancyPkg::occupancyT makeOccupancy(input int ld, input int st,
                                                                   input int iq, input int al);
    backendOccupancyPkg::occupancyT occ;
    occ.loadQueueCnt  = backendOccupancyPkg::lsqCntT'(ld);
    occ.storeQueueCnt = backendOccupancyPkg::lsqCntT'(st);
    occ.issueQueueCnt = backendOccupancyPkg::issueqCntT'(iq);
    occ.activeListCnt = backendOccupancyPkg::alCntT'(al);
    return occ;
  endfunction

  task automatic waitResetRelease();
    int cycles;
    cycles = 0;
    while (arstN_i !== 1'b1)
    begin
      @(posedge clk);
      cycles++;
      if (cycles > ResetTimeout)
      begin
        $display("Timeout: reset was never released");
        endInFailure();
      end
    end
  endtask

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////

  task automatic checkOutputs();
    instPacketPkg::branchMaskT   expMask;
    instPacketPkg::issueqPacketT expIq;
    instPacketPkg::alPacketT     expAl;
    instPacketPkg::lsqPacketT    expLsq;
    int                          loads;
    int                          stores;
    logic                        expStall;
    logic                        expReady;
    loads  = 0;
    stores = 0;
    for (int l = 0; l < `DISPATCH_WIDTH; l++)
    begin
      if (renamed[l].isLoad)
        loads++;
      if (renamed[l].isStore)
        stores++;
    end
    expStall = (int'(occupancy.loadQueueCnt) + loads > `SIZE_LSQ) ||
               (int'(occupancy.storeQueueCnt) + stores > `SIZE_LSQ) ||
               (int'(occupancy.issueQueueCnt) + `DISPATCH_WIDTH > `SIZE_ISSUEQ) ||
               (int'(occupancy.activeListCnt) + `DISPATCH_WIDTH > `SIZE_ACTIVELIST);
    expReady = !expStall && renameReady && !flagRecoverEx;

    assert (stallFrontEnd === expStall)
      else failMismatch("stallFrontEnd_o", 128'(stallFrontEnd), 128'(expStall));
    assert (backEndReady === expReady)
      else failMismatch("backEndReady_o", 128'(backEndReady), 128'(expReady));

    for (int l = 0; l < `DISPATCH_WIDTH; l++)
    begin
      for (int b = 0; b < `CHECKPOINTS; b++)
      begin
        expMask[b] = renamed[l].branchMask[b] && !(ctrlVerified && b == int'(ctrlVerifiedId));
      end
      // Issue packet is the renamed word minus logDest
      expIq            = renamed[l][$bits(instPacketPkg::issueqPacketT)-1:0];
      expIq.branchMask = expMask;
      expAl.isLoad      = renamed[l].isLoad;
      expAl.isStore     = renamed[l].isStore;
      expAl.pc          = renamed[l].pc;
      expAl.logDest     = renamed[l].logDest;
      expAl.physDest    = renamed[l].physDest;
      expAl.physOldDest = renamed[l].physOldDest;
      expLsq.branchMask = expMask;
      expLsq.isStore    = renamed[l].isStore;
      expLsq.isLoad     = renamed[l].isLoad;

      assert (updatedBranchMask[l] === expMask)
        else failMismatch($sformatf("updatedBranchMask_o[%0d]", l),
                          128'(updatedBranchMask[l]), 128'(expMask));
      assert (issueqPacket[l] === expIq)
        else failMismatch($sformatf("issueqPacket_o[%0d]", l),
                          128'(issueqPacket[l]), 128'(expIq));
      assert (alPacket[l] === expAl)
        else failMismatch($sformatf("alPacket_o[%0d]", l), 128'(alPacket[l]), 128'(expAl));
      assert (lsqPacket[l] === expLsq)
        else failMismatch($sformatf("lsqPacket_o[%0d]", l), 128'(lsqPacket[l]), 128'(expLsq));
    end
  endtask

  // Drive on the rising edge, check once the combinational paths settle
  task automatic driveGroup(input groupT grp, input backendOccupancyPkg::occupancyT occ,
                            input logic verified, input int id,
                            input logic ready, input logic recover);
    @(posedge clk);
    renamed        <= grp;
    occupancy      <= occ;
    ctrlVerified   <= verified;
    ctrlVerifiedId <= instPacketPkg::checkpointIdT'(id);
    renameReady    <= ready;
    flagRecoverEx  <= recover;
    #1;
    checkOutputs();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    groupT grp;
    void'($urandom(32'h25b5));
    renameReady    = 1'b0;
    flagRecoverEx  = 1'b0;
    ctrlVerified   = 1'b0;
    ctrlVerifiedId = '0;
    renamed        = '0;
    occupancy      = '0;
    waitResetRelease();

    driveGroup('0, makeOccupancy(0, 0, 0, 0), 1'b0, 0, 1'b0, 1'b0);   // Idle inputs
    driveGroup('0, makeOccupancy(0, 0, 0, 0), 1'b0, 0, 1'b1, 1'b0);

    grp = randomGroup();
    for (int l = 0; l < `DISPATCH_WIDTH; l++)
      grp[l].branchMask = '1;
    for (int id = 0; id < `CHECKPOINTS; id++)
      driveGroup(grp, makeOccupancy(0, 0, 0, 0), 1'b1, id, 1'b1, 1'b0);   // Every checkpoint
    driveGroup(grp, makeOccupancy(0, 0, 0, 0), 1'b0, 5, 1'b1, 1'b0);
    driveGroup(randomGroup(), makeOccupancy(0, 0, 0, 0), 1'b0, 2, 1'b1, 1'b0);

    // Queue boundaries on both sides
    driveGroup(mixGroup(0, 0), makeOccupancy(16, 16, 0, 0), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(1, 0), makeOccupancy(15, 0, 0, 0), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(2, 0), makeOccupancy(15, 0, 0, 0), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(4, 0), makeOccupancy(12, 0, 0, 0), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(4, 0), makeOccupancy(13, 0, 0, 0), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(0, 1), makeOccupancy(0, 15, 0, 0), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(0, 2), makeOccupancy(0, 15, 0, 0), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(0, 4), makeOccupancy(0, 12, 0, 0), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(0, 4), makeOccupancy(0, 13, 0, 0), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(0, 0), makeOccupancy(0, 0, 28, 60), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(0, 0), makeOccupancy(0, 0, 29, 0), 1'b0, 0, 1'b1, 1'b0);
    driveGroup(mixGroup(0, 0), makeOccupancy(0, 0, 0, 61), 1'b0, 0, 1'b1, 1'b0);

    // Ready gating with and without a stall
    for (int c = 0; c < 8; c++)
      driveGroup(mixGroup(1, 1), makeOccupancy(0, 0, (c >= 4) ? 32 : 0, 0), 1'b0, 0,
                 c[0], c[1]);

    for (int n = 0; n < RandomGroups; n++)
      driveGroup(randomGroup(),
                 makeOccupancy($urandom_range(16, 10), $urandom_range(16, 10),
                               $urandom_range(30, 20), $urandom_range(62, 52)),
                 1'($urandom_range(1, 0)), $urandom_range(7, 0),
                 1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));

    @(posedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule
